// File: common/mem_sys_pkg.sv
/*
 * Address and data format of the memory system.
 * Widths, field positions and the vector types shared by every block.
 */
package mem_sys_pkg;

   // Line geometry
   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_LINES      = 256;

   // Main memory size in 16-bit words
   localparam int MEM_WORDS      = 32768;

   // Byte address fields
   localparam int TAG_MSB   = 15;
   localparam int TAG_LSB   = 11;
   localparam int INDEX_MSB = 10;
   localparam int INDEX_LSB = 3;
   localparam int WORD_MSB  = 2;
   localparam int WORD_LSB  = 1;

   // Data word
   typedef logic [15:0] word_t;

   // Byte address, bit 0 always zero when legal
   typedef logic [15:0] addr_t;

   // Tag stored per line
   typedef logic [TAG_MSB-TAG_LSB:0] tag_t;

   // Line index
   typedef logic [INDEX_MSB-INDEX_LSB:0] index_t;

   // Word in line, doubles as bank number
   typedef logic [WORD_MSB-WORD_LSB:0] word_sel_t;

endpackage

// File: common/ctrl_pkg.sv
/*
 * Controller state encoding and main memory timing.
 */
package ctrl_pkg;

   // Request state machine
   typedef enum logic [3:0] {
      IDLE,
      COMPARE,
      CHECK,
      WB_READ,
      WB_DRAIN,
      FILL,
      FILL_DONE,
      RECOMPARE,
      DONE
   } ctrl_state_e;

   // Cycles from read acceptance to rd_valid
   localparam int MEM_RD_LATENCY   = 2;

   // Cycles a bank stays busy per access
   localparam int BANK_BUSY_CYCLES = 4;

endpackage

// File: common/cache_if.sv
/*
 * Link between the cache controller and the cache array.
 * Reads are combinational, writes land at the clock edge while enable is high.
 */
interface cache_if;

   // Controller side
   logic                  enable;
   logic                  comp;
   logic                  write;
   mem_sys_pkg::tag_t      tag_in;
   mem_sys_pkg::index_t    index;
   mem_sys_pkg::word_sel_t word_sel;
   mem_sys_pkg::word_t     data_in;

   // Array side
   logic                  hit;
   logic                  valid;
   logic                  dirty;
   mem_sys_pkg::tag_t      tag_out;
   mem_sys_pkg::word_t     data_out;

   modport ctrl (
      output enable, comp, write, tag_in, index, word_sel, data_in,
      input  hit, valid, dirty, tag_out, data_out
   );

   modport array (
      input  enable, comp, write, tag_in, index, word_sel, data_in,
      output hit, valid, dirty, tag_out, data_out
   );

endinterface

// File: common/mem_if.sv
/*
 * Link between the cache controller and the banked main memory.
 * A request is taken in a cycle with rd or wr high and stall low.
 */
interface mem_if;

   // Controller side
   logic               rd;
   logic               wr;
   mem_sys_pkg::addr_t addr;
   mem_sys_pkg::word_t data_in;

   // Memory side
   logic               stall;
   mem_sys_pkg::word_t data_out;
   logic               rd_valid;

   modport ctrl (
      output rd, wr, addr, data_in,
      input  stall, data_out, rd_valid
   );

   modport mem (
      input  rd, wr, addr, data_in,
      output stall, data_out, rd_valid
   );

endinterface

// File: hw/cache_ctrl/burst_counter.sv
/*
 * Word counters for a four-word burst. Issued and returned words are
 * counted apart, so reads may overlap with earlier returns.
 */
module burst_counter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   clear,
   input  logic                   issue,
   input  logic                   ret,
   output mem_sys_pkg::word_sel_t issue_idx,
   output mem_sys_pkg::word_sel_t ret_idx,
   output logic                   issue_last,
   output logic                   ret_last
);

   // One extra bit to count a full burst of four
   logic [2:0] issue_cnt;
   logic [2:0] ret_cnt;

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         issue_cnt <= '0;
         ret_cnt   <= '0;
      end else begin
         if (issue) issue_cnt <= issue_cnt + 3'd1;
         if (ret) ret_cnt <= ret_cnt + 3'd1;
      end
   end

   assign issue_idx  = issue_cnt[1:0];
   assign ret_idx    = ret_cnt[1:0];
   assign issue_last = (issue_cnt[1:0] == 2'd3);
   assign ret_last   = (ret_cnt[1:0] == 2'd3);

   // Only words already issued can come back
   a_ret_behind_issue: assert property (
      @(posedge clk) disable iff (!rst_n) (ret && !clear) |-> (ret_cnt < issue_cnt)
   );

endmodule

// File: hw/cache_ctrl/cache_ctrl.sv
/*
 * Request FSM of the data cache. Runs compare, victim writeback, line fill
 * and recompare, steering the cache array, the banked memory and the counter.
 */
module cache_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mem_sys_pkg::addr_t     addr,
   input  mem_sys_pkg::word_t     data_in,
   input  logic                   rd,
   input  logic                   wr,
   output mem_sys_pkg::word_t     data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err,
   cache_if.ctrl                  cache,
   mem_if.ctrl                    mem,
   output logic                   cnt_clear,
   output logic                   cnt_issue,
   output logic                   cnt_ret,
   input  mem_sys_pkg::word_sel_t issue_idx,
   input  mem_sys_pkg::word_sel_t ret_idx,
   input  logic                   issue_last,
   input  logic                   ret_last
);

   ctrl_pkg::ctrl_state_e  state;
   ctrl_pkg::ctrl_state_e  next_state;
   ctrl_pkg::ctrl_state_e  start_state;

   // Latched request
   mem_sys_pkg::addr_t     addr_q;
   mem_sys_pkg::word_t     data_q;
   logic                   wr_q;
   logic                   err_q;

   // Compare result captured for CHECK
   logic                   hit_q;
   logic                   valid_q;
   logic                   dirty_q;

   logic                   req;
   logic                   req_bad;
   logic                   accept;

   mem_sys_pkg::tag_t      tag_q;
   mem_sys_pkg::index_t    index_q;
   mem_sys_pkg::word_sel_t word_q;

   assign tag_q   = addr_q[mem_sys_pkg::TAG_MSB:mem_sys_pkg::TAG_LSB];
   assign index_q = addr_q[mem_sys_pkg::INDEX_MSB:mem_sys_pkg::INDEX_LSB];
   assign word_q  = addr_q[mem_sys_pkg::WORD_MSB:mem_sys_pkg::WORD_LSB];

   // Illegal: both strobes, or odd byte address
   assign req         = rd | wr;
   assign req_bad     = (rd & wr) | addr[0];
   assign start_state = req_bad ? ctrl_pkg::DONE : ctrl_pkg::COMPARE;

   // Busy from acceptance until the done cycle
   assign stall  = !((state == ctrl_pkg::IDLE) || done);
   assign accept = req & ~stall;

   assign data_out  = cache.data_out;
   assign cnt_issue = (mem.rd | mem.wr) & ~mem.stall;
   assign cnt_ret   = mem.rd_valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= ctrl_pkg::IDLE;
         wr_q    <= 1'b0;
         err_q   <= 1'b0;
         hit_q   <= 1'b0;
         valid_q <= 1'b0;
         dirty_q <= 1'b0;
      end else begin
         state <= next_state;
         if (accept) begin
            wr_q  <= wr;
            err_q <= req_bad;
         end
         if (state == ctrl_pkg::COMPARE) begin
            hit_q   <= cache.hit;
            valid_q <= cache.valid;
            dirty_q <= cache.dirty;
         end
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= addr;
         data_q <= data_in;
      end
   end

   always_comb begin
      next_state     = state;
      done           = 1'b0;
      cache_hit      = 1'b0;
      err            = 1'b0;
      cnt_clear      = 1'b0;
      // Array defaults to a read of the requested word
      cache.enable   = 1'b0;
      cache.comp     = 1'b0;
      cache.write    = 1'b0;
      cache.tag_in   = tag_q;
      cache.index    = index_q;
      cache.word_sel = word_q;
      cache.data_in  = data_q;
      // Memory defaults to the requested line
      mem.rd         = 1'b0;
      mem.wr         = 1'b0;
      mem.addr       = {tag_q, index_q, issue_idx, 1'b0};
      mem.data_in    = cache.data_out;

      case (state)
         ctrl_pkg::IDLE: begin
            if (req) next_state = start_state;
         end
         ctrl_pkg::COMPARE: begin
            // Compare read only, the write waits for a known hit
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            next_state   = ctrl_pkg::CHECK;
         end
         ctrl_pkg::CHECK: begin
            if (hit_q && valid_q) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               if (wr_q) begin
                  cache.enable = 1'b1;
                  cache.comp   = 1'b1;
                  cache.write  = 1'b1;
               end
               next_state = req ? start_state : ctrl_pkg::IDLE;
            end else begin
               cnt_clear  = 1'b1;
               next_state = (valid_q && dirty_q) ? ctrl_pkg::WB_READ : ctrl_pkg::FILL;
            end
         end
         ctrl_pkg::WB_READ: begin
            // Victim word goes out to its old address
            cache.word_sel = issue_idx;
            mem.wr         = 1'b1;
            mem.addr       = {cache.tag_out, index_q, issue_idx, 1'b0};
            if (!mem.stall && issue_last) next_state = ctrl_pkg::WB_DRAIN;
         end
         ctrl_pkg::WB_DRAIN: begin
            cnt_clear  = 1'b1;
            next_state = ctrl_pkg::FILL;
         end
         ctrl_pkg::FILL: begin
            mem.rd = 1'b1;
            if (!mem.stall && issue_last) next_state = ctrl_pkg::FILL_DONE;
         end
         ctrl_pkg::FILL_DONE: begin
            // Last word always returns here
            if (mem.rd_valid && ret_last) next_state = ctrl_pkg::RECOMPARE;
         end
         ctrl_pkg::RECOMPARE: begin
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            cache.write  = wr_q;
            next_state   = ctrl_pkg::DONE;
         end
         ctrl_pkg::DONE: begin
            done       = 1'b1;
            err        = err_q;
            next_state = req ? start_state : ctrl_pkg::IDLE;
         end
         default: next_state = ctrl_pkg::IDLE;
      endcase

      // Returned fill words land at the return index
      if (((state == ctrl_pkg::FILL) || (state == ctrl_pkg::FILL_DONE)) && mem.rd_valid) begin
         cache.enable   = 1'b1;
         cache.write    = 1'b1;
         cache.word_sel = ret_idx;
         cache.data_in  = mem.data_out;
      end
   end

   // Legal request keeps the port busy on the next cycle
   a_busy_after_accept: assert property (
      @(posedge clk) disable iff (!rst_n) (accept && !req_bad) |=> stall
   );

   // Stalled memory request stays put until taken
   a_mem_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      ((mem.rd || mem.wr) && mem.stall)
         |=> ($stable(mem.rd) && $stable(mem.wr) && $stable(mem.addr))
   );

endmodule

// File: hw/cache_array.sv
/*
 * Direct-mapped cache storage: tag, valid and dirty per line, four words
 * per line. Compare writes update a hit word, fill writes load a new line.
 */
module cache_array (
   input logic clk,
   input logic rst_n,
   cache_if.array cache
);

   mem_sys_pkg::tag_t  tag_mem  [mem_sys_pkg::NUM_LINES];
   mem_sys_pkg::word_t data_mem [mem_sys_pkg::NUM_LINES][mem_sys_pkg::WORDS_PER_LINE];

   logic [mem_sys_pkg::NUM_LINES-1:0] valid_bits;
   logic [mem_sys_pkg::NUM_LINES-1:0] dirty_bits;

   logic comp_wr;
   logic fill_wr;

   assign comp_wr = cache.enable & cache.write & cache.comp;
   assign fill_wr = cache.enable & cache.write & ~cache.comp;

   // Combinational lookup
   assign cache.hit      = (tag_mem[cache.index] == cache.tag_in);
   assign cache.valid    = valid_bits[cache.index];
   assign cache.dirty    = dirty_bits[cache.index];
   assign cache.tag_out  = tag_mem[cache.index];
   assign cache.data_out = data_mem[cache.index][cache.word_sel];

   // Line state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (fill_wr) begin
         valid_bits[cache.index] <= 1'b1;
         dirty_bits[cache.index] <= 1'b0;
      end else if (comp_wr && cache.hit && cache.valid) begin
         dirty_bits[cache.index] <= 1'b1;
      end
   end

   // Tag and data storage
   always_ff @(posedge clk) begin
      if (fill_wr) begin
         tag_mem[cache.index]                 <= cache.tag_in;
         data_mem[cache.index][cache.word_sel] <= cache.data_in;
      end else if (comp_wr && cache.hit && cache.valid) begin
         data_mem[cache.index][cache.word_sel] <= cache.data_in;
      end
   end

   // Controller only writes on a known hit
   a_comp_wr_hit: assert property (
      @(posedge clk) disable iff (!rst_n) comp_wr |-> (cache.hit && cache.valid)
   );

endmodule

// File: hw/bank_mem.sv
/*
 * Four-bank main memory model. Each access holds its bank busy for a few
 * cycles; reads return through a fixed-latency pipeline with rd_valid.
 */
module bank_mem (
   input logic clk,
   input logic rst_n,
   mem_if.mem  mem
);

   mem_sys_pkg::word_t mem_array [mem_sys_pkg::MEM_WORDS];

   // Remaining busy cycles per bank
   logic [2:0] busy_cnt [mem_sys_pkg::WORDS_PER_LINE];

   logic [ctrl_pkg::MEM_RD_LATENCY-1:0] pipe_valid;
   mem_sys_pkg::word_t                  pipe_data [ctrl_pkg::MEM_RD_LATENCY];

   mem_sys_pkg::word_sel_t bank;
   logic                   accept;

   assign bank      = mem.addr[mem_sys_pkg::WORD_MSB:mem_sys_pkg::WORD_LSB];
   assign mem.stall = (mem.rd | mem.wr) & (busy_cnt[bank] != 3'd0);
   assign accept    = (mem.rd | mem.wr) & ~mem.stall;

   // Simulation model starts from a zeroed image
   initial begin
      for (int i = 0; i < mem_sys_pkg::MEM_WORDS; i++) mem_array[i] = '0;
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < mem_sys_pkg::WORDS_PER_LINE; b++) begin
         if (!rst_n) busy_cnt[b] <= 3'd0;
         else if (accept && (bank == b[1:0])) busy_cnt[b] <= 3'(ctrl_pkg::BANK_BUSY_CYCLES - 1);
         else if (busy_cnt[b] != 3'd0) busy_cnt[b] <= busy_cnt[b] - 3'd1;
      end
   end

   // Word addressed storage
   always_ff @(posedge clk) begin
      if (accept && mem.wr) mem_array[mem.addr[15:mem_sys_pkg::WORD_LSB]] <= mem.data_in;
   end

   // Read return pipeline
   always_ff @(posedge clk) begin
      if (!rst_n) pipe_valid <= '0;
      else pipe_valid <= {pipe_valid[ctrl_pkg::MEM_RD_LATENCY-2:0], accept & mem.rd};
   end

   always_ff @(posedge clk) begin
      pipe_data[0] <= mem_array[mem.addr[15:mem_sys_pkg::WORD_LSB]];
      for (int s = 1; s < ctrl_pkg::MEM_RD_LATENCY; s++) pipe_data[s] <= pipe_data[s-1];
   end

   assign mem.rd_valid = pipe_valid[ctrl_pkg::MEM_RD_LATENCY-1];
   assign mem.data_out = pipe_data[ctrl_pkg::MEM_RD_LATENCY-1];

endmodule

// File: hw/mem_system.sv
/*
 * Top of the cached memory system. Plain request ports outside,
 * controller, counter, cache array and banked memory inside.
 */
module mem_system (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_sys_pkg::addr_t addr,
   input  mem_sys_pkg::word_t data_in,
   input  logic               rd,
   input  logic               wr,
   output mem_sys_pkg::word_t data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);

   cache_if cache_bus ();
   mem_if   mem_bus ();

   // Burst counter handshake
   logic                   cnt_clear;
   logic                   cnt_issue;
   logic                   cnt_ret;
   mem_sys_pkg::word_sel_t issue_idx;
   mem_sys_pkg::word_sel_t ret_idx;
   logic                   issue_last;
   logic                   ret_last;

   cache_ctrl u_cache_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr       (addr),
      .data_in    (data_in),
      .rd         (rd),
      .wr         (wr),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err),
      .cache      (cache_bus.ctrl),
      .mem        (mem_bus.ctrl),
      .cnt_clear  (cnt_clear),
      .cnt_issue  (cnt_issue),
      .cnt_ret    (cnt_ret),
      .issue_idx  (issue_idx),
      .ret_idx    (ret_idx),
      .issue_last (issue_last),
      .ret_last   (ret_last)
   );

   burst_counter u_burst_counter (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear      (cnt_clear),
      .issue      (cnt_issue),
      .ret        (cnt_ret),
      .issue_idx  (issue_idx),
      .ret_idx    (ret_idx),
      .issue_last (issue_last),
      .ret_last   (ret_last)
   );

   cache_array u_cache_array (
      .clk   (clk),
      .rst_n (rst_n),
      .cache (cache_bus.array)
   );

   bank_mem u_bank_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .mem   (mem_bus.mem)
   );

endmodule

// File: verif/tb_clk_gen.sv
/*
 * Free-running testbench clock with a period of 10 time units.
 */
module tb_clk_gen (
   output logic clk
);

   localparam int HALF_PERIOD = 5;

   initial clk = 1'b0;

   always #HALF_PERIOD clk = ~clk;

endmodule

// File: verif/tb_mem_system.sv
/*
 * Testbench of the cached memory system. Directed and seeded random requests
 * run against a reference model of the memory image and the direct-mapped tag table.
 */
module tb_mem_system;

   localparam int NUM_DIRECTED   = 12;
   localparam int NUM_RANDOM     = 400;
   // Compare, check, four issues, last return, recompare, done
   localparam int CLEAN_MISS_MIN = 2 + mem_sys_pkg::WORDS_PER_LINE + ctrl_pkg::MEM_RD_LATENCY + 2;
   // Writeback adds four issues and the drain cycle
   localparam int DIRTY_MISS_MIN = CLEAN_MISS_MIN + mem_sys_pkg::WORDS_PER_LINE + 1;
   localparam int WORST_MISS     = DIRTY_MISS_MIN + 4 * ctrl_pkg::BANK_BUSY_CYCLES;
   // Worst case per request plus idle gaps, with a margin
   localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * (WORST_MISS + 2) + 100;

   logic               clk;
   logic               rst_n;
   mem_sys_pkg::addr_t addr;
   mem_sys_pkg::word_t data_in;
   logic               rd;
   logic               wr;
   mem_sys_pkg::word_t data_out;
   logic               done;
   logic               stall;
   logic               cache_hit;
   logic               err;

   int errors  = 0;
   int accepts = 0;
   int dones   = 0;
   int cycles  = 0;

   // Reference model
   mem_sys_pkg::word_t model_mem   [mem_sys_pkg::MEM_WORDS];
   mem_sys_pkg::tag_t  model_tag   [mem_sys_pkg::NUM_LINES];
   logic               model_valid [mem_sys_pkg::NUM_LINES];
   logic               model_dirty [mem_sys_pkg::NUM_LINES];

   // Small pools so that hits, conflicts and evictions all show up
   mem_sys_pkg::tag_t   tag_pool   [4] = '{5'd0, 5'd1, 5'd2, 5'd31};
   mem_sys_pkg::index_t index_pool [4] = '{8'h00, 8'h10, 8'h20, 8'hff};

   tb_clk_gen u_clk_gen (
      .clk (clk)
   );

   mem_system u_mem_system (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   task automatic check_value(input string what, input int got, input int expected);
      if (got != expected) begin
         errors++;
         $display("Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                  $time, what, got, expected);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   function automatic mem_sys_pkg::addr_t build_addr(input mem_sys_pkg::tag_t t,
                                                     input mem_sys_pkg::index_t ix,
                                                     input mem_sys_pkg::word_sel_t w);
      return {t, ix, w, 1'b0};
   endfunction

   function automatic mem_sys_pkg::addr_t random_addr();
      logic [1:0]             t_sel;
      logic [1:0]             i_sel;
      mem_sys_pkg::word_sel_t w;
      t_sel = 2'($urandom_range(0, 3));
      i_sel = 2'($urandom_range(0, 3));
      w     = 2'($urandom_range(0, 3));
      return build_addr(tag_pool[t_sel], index_pool[i_sel], w);
   endfunction

   // One request from a falling edge to its done cycle, checked against the model
   task automatic run_access(input mem_sys_pkg::addr_t a, input mem_sys_pkg::word_t d,
                             input logic r, input logic w, output logic hit_o);
      mem_sys_pkg::tag_t   t;
      mem_sys_pkg::index_t ix;
      logic                bad;
      logic                exp_hit;
      logic                exp_dirty;
      mem_sys_pkg::word_t  exp_data;
      int                  lat;
      int                  bound;
      t         = a[mem_sys_pkg::TAG_MSB:mem_sys_pkg::TAG_LSB];
      ix        = a[mem_sys_pkg::INDEX_MSB:mem_sys_pkg::INDEX_LSB];
      bad       = (r && w) || a[0];
      exp_hit   = model_valid[ix] && (model_tag[ix] == t);
      // Valid dirty victim means a writeback before the fill
      exp_dirty = !exp_hit && model_valid[ix] && model_dirty[ix];
      exp_data  = model_mem[a[15:mem_sys_pkg::WORD_LSB]];
      addr      = a;
      data_in   = d;
      rd        = r;
      wr        = w;
      while (stall) begin
         check_value("stall low when a request is driven", int'(stall), 0);
         @(negedge clk);
      end
      accepts++;
      @(negedge clk);
      rd  = 1'b0;
      wr  = 1'b0;
      lat = 1;
      while (!done) begin
         check_value("stall high while a request runs", int'(stall), 1);
         @(negedge clk);
         lat++;
      end
      hit_o = cache_hit;
      check_value("err flag", int'(err), int'(bad));
      if (bad) begin
         check_value("illegal request latency", lat, 1);
      end else begin
         check_value("cache_hit", int'(cache_hit), int'(exp_hit));
         if (exp_hit) begin
            check_value("hit latency", lat, 2);
         end else begin
            bound = exp_dirty ? DIRTY_MISS_MIN : CLEAN_MISS_MIN;
            check_value("miss latency reaches its lower bound", int'(lat >= bound), 1);
         end
         if (r) check_value("read data", int'(data_out), int'(exp_data));
         // Line is resident afterwards, a fill leaves it clean
         if (!exp_hit) model_dirty[ix] = 1'b0;
         model_valid[ix] = 1'b1;
         model_tag[ix]   = t;
         if (w) begin
            model_mem[a[15:mem_sys_pkg::WORD_LSB]] = d;
            model_dirty[ix] = 1'b1;
         end
      end
   endtask

   // Done pulses and the handshake rule of the done cycle
   always @(negedge clk) begin
      if (rst_n && done) begin
         dones <= dones + 1;
         check_value("stall low in a done cycle", int'(stall), 0);
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   initial begin
      mem_sys_pkg::addr_t a;
      logic               hit;
      int                 kind;
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      void'($urandom(32'hd522));
      for (int i = 0; i < mem_sys_pkg::MEM_WORDS; i++) model_mem[i] = '0;
      for (int i = 0; i < mem_sys_pkg::NUM_LINES; i++) begin
         model_tag[i]   = '0;
         model_valid[i] = 1'b0;
         model_dirty[i] = 1'b0;
      end
      idle_cycles(2);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("done after reset", int'(done), 0);
      check_value("stall after reset", int'(stall), 0);
      check_value("cache_hit after reset", int'(cache_hit), 0);
      check_value("err after reset", int'(err), 0);

      // Cold read misses and returns zero, the repeat hits
      run_access(build_addr(5'd1, 8'h10, 2'd2), 16'h0000, 1'b1, 1'b0, hit);
      check_value("cold read misses", int'(hit), 0);
      run_access(build_addr(5'd1, 8'h10, 2'd2), 16'h0000, 1'b1, 1'b0, hit);
      check_value("repeated read hits", int'(hit), 1);

      // Write then read back in a resident line
      run_access(build_addr(5'd1, 8'h10, 2'd1), 16'hbeef, 1'b0, 1'b1, hit);
      check_value("write to resident line hits", int'(hit), 1);
      run_access(build_addr(5'd1, 8'h10, 2'd1), 16'h0000, 1'b1, 1'b0, hit);
      check_value("read after write hits", int'(hit), 1);

      // Write miss allocates the line
      run_access(build_addr(5'd2, 8'h20, 2'd0), 16'h1234, 1'b0, 1'b1, hit);
      check_value("write miss", int'(hit), 0);
      run_access(build_addr(5'd2, 8'h20, 2'd0), 16'h0000, 1'b1, 1'b0, hit);
      check_value("read of allocated line hits", int'(hit), 1);

      // Conflict evicts the dirty line, which must come back from memory
      run_access(build_addr(5'd3, 8'h20, 2'd0), 16'h0000, 1'b1, 1'b0, hit);
      check_value("conflicting tag misses", int'(hit), 0);
      run_access(build_addr(5'd2, 8'h20, 2'd0), 16'h0000, 1'b1, 1'b0, hit);
      check_value("evicted line misses", int'(hit), 0);

      // Illegal requests leave cache and memory alone
      run_access(build_addr(5'd2, 8'h20, 2'd0), 16'h5555, 1'b1, 1'b1, hit);
      run_access(build_addr(5'd4, 8'h20, 2'd0) | 16'h0001, 16'hdead, 1'b0, 1'b1, hit);
      run_access(build_addr(5'd4, 8'h20, 2'd3) | 16'h0001, 16'h0000, 1'b1, 1'b0, hit);
      run_access(build_addr(5'd2, 8'h20, 2'd0), 16'h0000, 1'b1, 1'b0, hit);
      check_value("line kept after illegal requests", int'(hit), 1);

      // Random mix, some back to back in the done cycle
      for (int i = 0; i < NUM_RANDOM; i++) begin
         idle_cycles(int'($urandom_range(0, 2)));
         a    = random_addr();
         kind = int'($urandom_range(0, 15));
         if (kind == 0) run_access(a, 16'($urandom), 1'b1, 1'b1, hit);
         else if (kind == 1) run_access(a | 16'h0001, 16'($urandom), 1'b1, 1'b0, hit);
         else if (kind < 9) run_access(a, 16'($urandom), 1'b1, 1'b0, hit);
         else run_access(a, 16'($urandom), 1'b0, 1'b1, hit);
      end

      // Let the last done reach the monitor
      idle_cycles(3);
      check_value("one done per accepted request", dones, accepts);
      $display("Run finished: %0d requests, %0d done pulses, %0d errors",
               accepts, dones, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: mem_system.f
common/mem_sys_pkg.sv
common/ctrl_pkg.sv
common/cache_if.sv
common/mem_if.sv
hw/cache_ctrl/burst_counter.sv
hw/cache_ctrl/cache_ctrl.sv
hw/cache_array.sv
hw/bank_mem.sv
hw/mem_system.sv
verif/tb_clk_gen.sv
verif/tb_mem_system.sv

// File: Makefile
# Verilator build for the cached memory system

VERILATOR  ?= verilator
TOP        := tb_mem_system
FILELIST   := mem_system.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
